//--- cga_idb.f
cga_idb_pkg.sv
cga_idb_if.sv
cga_regif.sv
cga_idbctl.sv
cga_pgsreg.sv
cga_intctl.sv
cga_idb_top.sv
tb_cga_idb.sv

//--- Makefile
TOP := tb_cga_idb

.PHONY: sim clean

# build with verilator, run, then look for the pass line in the log.
sim:
	verilator --binary --timing --timescale 1ns/100ps --top-module $(TOP) \
		-Mdir obj_dir -f cga_idb.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb_cga_idb.sv
// directed testbench for the IDB read-back path.
// wishbone master drives on the rising edge, read data and ack are sampled on the falling edge.
// stimulus comes from $urandom with a fixed seed, so every run is the same.
`timescale 1ns/100ps

module tb_cga_idb;

  // address map and read-back rules of the register layout.
  localparam logic [2:0]  ADR_PGS     = 3'd0;
  localparam logic [2:0]  ADR_PCR     = 3'd1;
  localparam logic [2:0]  ADR_PICS    = 3'd2;
  localparam logic [2:0]  ADR_PICV    = 3'd3;
  localparam logic [2:0]  ADR_PICMASK = 3'd4;
  localparam logic [15:0] PCR_KEEP    = 16'hff87;
  // levels 0, 2, 3, 5 and 6 enabled, levels 1, 4 and 7 masked.
  localparam logic [15:0] IRQ_MASK    = 16'h5a6d;
  localparam int          CYCLE_LIMIT = 200 * 6;

  logic        mclk;
  logic        reset;
  logic        cyc;
  logic        stb;
  logic        we;
  logic [2:0]  adr;
  logic [15:0] dat_i;
  logic [15:0] dat_o;
  logic        ack;
  logic [15:0] ext_data;
  logic        fetch_n;
  logic        vacc_n;
  logic        pviol;
  logic [11:0] la;
  logic [7:0]  irq_req;
  logic        higs_n;
  logic        logs_n;
  logic        pd;

  int          errors;
  int          checks;
  int          test_errors;
  int          tests_run;
  int          cycles;
  // reference state of the registers.
  logic [15:0] pcr_model;
  logic [15:0] pgs_model;
  logic [7:0]  pend_model;
  logic [2:0]  pics_model;

  cga_idb_top cga_idb_top_i (
    .mclk     (mclk),
    .reset    (reset),
    .cyc      (cyc),
    .stb      (stb),
    .we       (we),
    .adr      (adr),
    .dat_i    (dat_i),
    .dat_o    (dat_o),
    .ack      (ack),
    .ext_data (ext_data),
    .fetch_n  (fetch_n),
    .vacc_n   (vacc_n),
    .pviol    (pviol),
    .la       (la),
    .irq_req  (irq_req),
    .higs_n   (higs_n),
    .logs_n   (logs_n),
    .pd       (pd)
  );

  initial begin
    mclk = 1'b0;
    forever #50 mclk = ~mclk;
  end

  // watchdog, the run must end well before this many cycles.
  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge mclk);
      cycles++;
    end
    $display("timeout: the tests did not finish within %0d clock cycles", CYCLE_LIMIT);
    $display("Errors found");
    $finish;
  end

  function automatic logic [15:0] rand16();
    logic [31:0] r;
    r = $urandom;
    return r[15:0];
  endfunction

  // page-status word: fetch, valid, two zero bits, page.
  function automatic logic [15:0] pgs_word(logic fetch_n_v, logic valid_v, logic [11:0] page);
    return {~fetch_n_v, valid_v, 2'b00, page};
  endfunction

  // status word: logs_n, higs_n, in-service level.
  function automatic logic [15:0] pics_word(logic [2:0] lvl);
    return {11'd0, logs_n, higs_n, lvl};
  endfunction

  // vector word: pd above the level.
  function automatic logic [15:0] picv_word(logic [2:0] lvl);
    return {12'd0, pd, lvl};
  endfunction

  task automatic check(input logic [15:0] got, input logic [15:0] exp, input string msg);
    checks++;
    if (got !== exp) begin
      $display("FAILED at %0t: %s, got %h, expected %h", $time, msg, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic end_test(input string name);
    $display("test %0d (%s) done, %0d mismatches", tests_run + 1, name, test_errors);
    tests_run++;
    test_errors = 0;
  endtask

  task automatic start_req(input logic we_v, input logic [2:0] adr_v, input logic [15:0] dat_v);
    @(posedge mclk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= we_v;
    adr   <= adr_v;
    dat_i <= dat_v;
  endtask

  // lat counts falling edges until ack, 2 means ack one cycle after stb is sampled.
  task automatic wait_ack(output logic [15:0] data, output int lat);
    lat = 0;
    do begin
      @(negedge mclk);
      lat++;
    end while (!ack);
    data = dat_o;
  endtask

  task automatic end_req();
    @(posedge mclk);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic wb_write(input logic [2:0] adr_v, input logic [15:0] dat_v);
    logic [15:0] unused;
    int          lat;
    start_req(1'b1, adr_v, dat_v);
    wait_ack(unused, lat);
    end_req();
  endtask

  task automatic wb_read(input logic [2:0] adr_v, output logic [15:0] data);
    int lat;
    start_req(1'b0, adr_v, 16'h0000);
    wait_ack(data, lat);
    end_req();
  endtask

  // violation on one access, captured on the edge where pviol is sampled high.
  task automatic raise_violation(input logic [11:0] la_v, input logic fetch_n_v);
    @(posedge mclk);
    pviol   <= 1'b1;
    vacc_n  <= 1'b0;
    la      <= la_v;
    fetch_n <= fetch_n_v;
    @(posedge mclk);
    pviol   <= 1'b0;
    vacc_n  <= 1'b1;
  endtask

  task automatic reset_test();
    logic [15:0] got;
    logic [15:0] v;
    wb_read(ADR_PGS, got);
    check(got, 16'h0000, "pgs after reset");
    wb_read(ADR_PCR, got);
    check(got, 16'h0000, "pcr after reset");
    wb_read(ADR_PICS, got);
    check(got, pics_word(3'd0), "status after reset");
    wb_read(ADR_PICV, got);
    check(got, picv_word(3'd0), "vector after reset");
    // the status pins go straight to the bus, so each is read in both states.
    @(posedge mclk);
    higs_n <= ~higs_n;
    logs_n <= ~logs_n;
    pd     <= ~pd;
    wb_read(ADR_PICS, got);
    check(got, pics_word(3'd0), "status with pins inverted");
    wb_read(ADR_PICV, got);
    check(got, picv_word(3'd0), "vector with pd inverted");
    wb_read(ADR_PICMASK, got);
    check(got, 16'h0000, "mask after reset");
    // unmapped addresses show the rest of the IDB.
    for (int a = 5; a < 8; a++) begin
      v = rand16();
      @(posedge mclk);
      ext_data <= v;
      wb_read(3'(a), got);
      check(got, v, "external data");
    end
  endtask

  task automatic write_test();
    logic [15:0] got;
    logic [15:0] v;
    repeat (3) begin
      v = rand16();
      wb_write(ADR_PCR, v);
      pcr_model = v;
      wb_read(ADR_PCR, got);
      check(got, v & PCR_KEEP, "pcr read-back");
      v = rand16();
      wb_write(ADR_PICMASK, v);
      wb_read(ADR_PICMASK, got);
      check(got, v, "mask read-back");
    end
  endtask

  task automatic pgs_test();
    logic [15:0] got;
    logic [15:0] v1;
    logic [15:0] v2;
    logic [15:0] v3;
    v1 = rand16();
    v2 = ~v1;
    v3 = rand16();
    raise_violation(v1[11:0], v1[15]);
    // locked, so this one is dropped.
    raise_violation(v2[11:0], v2[15]);
    wb_read(ADR_PGS, got);
    check(got, pgs_word(v1[15], 1'b1, v1[11:0]), "first violation held");
    wb_read(ADR_PGS, got);
    check(got, pgs_word(v1[15], 1'b0, v1[11:0]), "valid cleared by read");
    raise_violation(v3[11:0], v3[15]);
    wb_read(ADR_PGS, got);
    check(got, pgs_word(v3[15], 1'b1, v3[11:0]), "violation after unlock");
  endtask

  task automatic irq_test();
    logic [15:0] got;
    logic [15:0] v;
    logic [7:0]  req;
    logic [7:0]  act;
    wb_write(ADR_PICMASK, IRQ_MASK);
    for (int round = 0; round < 2; round++) begin
      v = rand16();
      req = v[7:0];
      // one masked and one enabled level are always raised.
      req[7] = 1'b1;
      req[5] = 1'b1;
      @(posedge mclk);
      irq_req <= req;
      @(posedge mclk);
      irq_req <= 8'h00;
      pend_model = pend_model | req;
      act = pend_model & IRQ_MASK[7:0];
      // the vector has to walk the enabled levels from the top.
      for (int lvl = 7; lvl >= 0; lvl--) begin
        if (act[lvl]) begin
          wb_read(ADR_PICV, got);
          check(got, picv_word(3'(lvl)), "vector order");
          pend_model[lvl] = 1'b0;
          pics_model = 3'(lvl);
          wb_read(ADR_PICS, got);
          check(got, pics_word(pics_model), "status after ack");
        end
      end
      wb_read(ADR_PICV, got);
      check(got, picv_word(3'd0), "vector with nothing pending");
      wb_read(ADR_PICS, got);
      check(got, pics_word(pics_model), "status kept when idle");
    end
  endtask

  // stb goes up while cyc is low, then cyc goes up alone. no cycle ever has both.
  task automatic abort_test();
    logic [15:0] got;
    int          seen;
    seen = 0;
    @(posedge mclk);
    stb   <= 1'b1;
    we    <= 1'b1;
    adr   <= ADR_PCR;
    dat_i <= ~pcr_model;
    @(negedge mclk);
    if (ack) seen++;
    @(posedge mclk);
    stb <= 1'b0;
    cyc <= 1'b1;
    @(negedge mclk);
    if (ack) seen++;
    @(posedge mclk);
    cyc <= 1'b0;
    we  <= 1'b0;
    repeat (3) begin
      @(negedge mclk);
      if (ack) seen++;
    end
    check(16'(seen), 16'd0, "ack cycles during abort");
    wb_read(ADR_PCR, got);
    check(got, pcr_model & PCR_KEEP, "pcr after abort");
  endtask

  task automatic b2b_test();
    logic [15:0] got;
    logic [15:0] v;
    int          lat;
    v = rand16();
    // a held violation shows any unlock caused by the writes below.
    raise_violation(v[11:0], v[15]);
    pgs_model = pgs_word(v[15], 1'b1, v[11:0]);
    // stb stays high from one transfer into the next.
    start_req(1'b1, ADR_PGS, v);
    wait_ack(got, lat);
    check(16'(lat), 16'd2, "ack timing, write to pgs");
    start_req(1'b1, ADR_PICS, ~v);
    wait_ack(got, lat);
    check(16'(lat), 16'd2, "ack timing, write to status");
    start_req(1'b0, ADR_PICV, 16'h0000);
    wait_ack(got, lat);
    check(16'(lat), 16'd2, "ack timing, vector read");
    check(got, picv_word(3'd0), "vector after read-only writes");
    end_req();
    @(negedge mclk);
    check({15'd0, ack}, 16'd0, "ack after last transfer");
    wb_read(ADR_PGS, got);
    check(got, pgs_model, "pgs after read-only write");
    wb_read(ADR_PICS, got);
    check(got, pics_word(pics_model), "status after read-only write");
    // level 7 is still pending behind the mask.
    wb_write(ADR_PICMASK, 16'h00ff);
    wb_read(ADR_PICV, got);
    check(got, picv_word(3'd7), "masked level kept pending");
  endtask

  initial begin
    logic [15:0] v;
    errors      = 0;
    checks      = 0;
    test_errors = 0;
    tests_run   = 0;
    pcr_model   = 16'h0000;
    pgs_model   = 16'h0000;
    pend_model  = 8'h00;
    pics_model  = 3'd0;
    void'($urandom(32'hb9b8_e557));
    v = rand16();
    reset    <= 1'b1;
    cyc      <= 1'b0;
    stb      <= 1'b0;
    we       <= 1'b0;
    adr      <= 3'd0;
    dat_i    <= 16'h0000;
    ext_data <= 16'h0000;
    fetch_n  <= 1'b1;
    vacc_n   <= 1'b1;
    pviol    <= 1'b0;
    la       <= 12'h000;
    irq_req  <= 8'h00;
    // higs_n and logs_n start apart so a swap of the two bits shows.
    higs_n   <= v[0];
    logs_n   <= ~v[0];
    pd       <= v[2];
    repeat (10) @(posedge mclk);
    reset <= 1'b0;

    reset_test();
    end_test("reset values");
    write_test();
    end_test("pcr and mask writes");
    pgs_test();
    end_test("page status");
    irq_test();
    end_test("interrupts");
    abort_test();
    end_test("abort");
    b2b_test();
    end_test("back-to-back");

    $display("tests %0d, checks %0d, mismatches %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- cga_idb_top.sv
// IDB read-back path top level with plain ports.
// dat_o follows the IDB and is only meaningful while ack is high.
// addresses 5 to 7 return ext_data unchanged.
`timescale 1ns/100ps

module cga_idb_top
  import cga_idb_pkg::*;
(
  input  logic                  mclk,
  input  logic                  reset,
  input  logic                  cyc,
  input  logic                  stb,
  input  logic                  we,
  input  logic [ADR_W-1:0]      adr,
  input  logic [IDB_W-1:0]      dat_i,
  output logic [IDB_W-1:0]      dat_o,
  output logic                  ack,
  input  logic [IDB_W-1:0]      ext_data,
  input  logic                  fetch_n,
  input  logic                  vacc_n,
  input  logic                  pviol,
  input  logic [PGS_PAGE_W-1:0] la,
  input  logic [PIC_LEVELS-1:0] irq_req,
  input  logic                  higs_n,
  input  logic                  logs_n,
  input  logic                  pd
);

  logic [IDB_W-1:0]     pcr;
  logic [IDB_W-1:0]     pgs;
  logic [IDB_W-1:0]     picmask;
  logic [PIC_LVL_W-1:0] pics;
  logic [PIC_LVL_W-1:0] picv;

  // enables, strobes and write data between the blocks.
  cga_idb_if idb_bus ();

  cga_regif regif_i (
    .mclk  (mclk),
    .reset (reset),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .dat_i (dat_i),
    .ack   (ack),
    .pcr   (pcr),
    .bus   (idb_bus.dec)
  );

  // the selected IDB word is the read data.
  cga_idbctl idbctl_i (
    .bus      (idb_bus.sel),
    .ext_data (ext_data),
    .pcr      (pcr),
    .pgs      (pgs),
    .picmask  (picmask),
    .pics     (pics),
    .picv     (picv),
    .higs_n   (higs_n),
    .logs_n   (logs_n),
    .pd       (pd),
    .idb      (dat_o)
  );

  cga_pgsreg pgsreg_i (
    .mclk    (mclk),
    .reset   (reset),
    .fetch_n (fetch_n),
    .vacc_n  (vacc_n),
    .pviol   (pviol),
    .la      (la),
    .bus     (idb_bus.pgs),
    .pgs     (pgs)
  );

  cga_intctl intctl_i (
    .mclk    (mclk),
    .reset   (reset),
    .irq_req (irq_req),
    .bus     (idb_bus.pic),
    .picmask (picmask),
    .pics    (pics),
    .picv    (picv)
  );

endmodule

//--- cga_intctl.sv
// 8-level interrupt controller with sticky pending bits.
// level 7 has the highest priority, level 0 reads as "none" too.
// a vector read acknowledges the shown level, nothing happens if none is pending.
`timescale 1ns/100ps

module cga_intctl
  import cga_idb_pkg::*;
(
  input  logic                  mclk,
  input  logic                  reset,
  input  logic [PIC_LEVELS-1:0] irq_req,
  cga_idb_if.pic                bus,
  output logic [IDB_W-1:0]      picmask,
  output logic [PIC_LVL_W-1:0]  pics,
  output logic [PIC_LVL_W-1:0]  picv
);

  logic [PIC_LEVELS-1:0] pending;
  logic [PIC_LEVELS-1:0] active;
  logic [PIC_LEVELS-1:0] clr;
  logic                  any_active;
  logic                  do_ack;

  // only levels enabled in the low mask byte can be served.
  assign active     = pending & picmask[PIC_LEVELS-1:0];
  assign any_active = |active;

  // acknowledge only when the vector points at a real request.
  assign do_ack = bus.rd_picv & any_active;

  // highest active level wins, later loop passes override earlier ones.
  always_comb begin
    picv = '0;
    for (int i = 0; i < PIC_LEVELS; i++) begin
      if (active[i]) begin
        picv = i[PIC_LVL_W-1:0];
      end
    end
  end

  // one-hot clear of the level being acknowledged.
  always_comb begin
    clr = '0;
    if (do_ack) begin
      clr[picv] = 1'b1;
    end
  end

  // pending bits are sticky.
  // a new request on the same edge as the clear is kept.
  always_ff @(posedge mclk) begin
    if (reset) begin
      pending <= '0;
    end else begin
      pending <= (pending & ~clr) | irq_req;
    end
  end

  // in-service level, loaded on acknowledge.
  always_ff @(posedge mclk) begin
    if (reset) begin
      pics <= '0;
    end else if (do_ack) begin
      pics <= picv;
    end
  end

  // mask register.
  // upper byte is plain software storage and reads back unchanged.
  always_ff @(posedge mclk) begin
    if (reset) begin
      picmask <= '0;
    end else if (bus.wr_mask) begin
      picmask <= bus.wdat;
    end
  end

endmodule

//--- cga_pgsreg.sv
// page-status register, holds the first protection violation.
// it stays locked until a read of the word clears the valid bit.
// page and fetch bits keep their last value after the clear.
`timescale 1ns/100ps

module cga_pgsreg
  import cga_idb_pkg::*;
(
  input  logic                  mclk,
  input  logic                  reset,
  input  logic                  fetch_n,
  input  logic                  vacc_n,
  input  logic                  pviol,
  input  logic [PGS_PAGE_W-1:0] la,
  cga_idb_if.pgs                bus,
  output logic [IDB_W-1:0]      pgs
);

  logic                  fetch;
  logic                  valid;
  logic [PGS_PAGE_W-1:0] page;
  logic                  capture;

  // a violation on a valid access, taken only while unlocked.
  assign capture = pviol & ~vacc_n & ~valid;

  always_ff @(posedge mclk) begin
    if (reset) begin
      fetch <= 1'b0;
      valid <= 1'b0;
      page  <= '0;
    end else if (capture) begin
      // fetch bit is high for an instruction fetch.
      fetch <= ~fetch_n;
      valid <= 1'b1;
      page  <= la;
    end else if (bus.rd_pgs) begin
      // read unlocks, the rest of the word stays.
      valid <= 1'b0;
    end
  end

  // assemble the status word, bits 13 and 12 stay zero.
  always_comb begin
    pgs                   = '0;
    pgs[PGS_FETCH_BIT]    = fetch;
    pgs[PGS_VALID_BIT]    = valid;
    pgs[PGS_PAGE_W-1:0]   = page;
  end

endmodule

//--- cga_idbctl.sv
// IDB source selector, an AND-OR of the enabled source per bit.
// with no enable low the external data drives the bus.
// enables come straight from the decoder, no registering here.
`timescale 1ns/100ps

module cga_idbctl
  import cga_idb_pkg::*;
(
  cga_idb_if.sel               bus,
  input  logic [IDB_W-1:0]     ext_data,
  input  logic [IDB_W-1:0]     pcr,
  input  logic [IDB_W-1:0]     pgs,
  input  logic [IDB_W-1:0]     picmask,
  input  logic [PIC_LVL_W-1:0] pics,
  input  logic [PIC_LVL_W-1:0] picv,
  input  logic                 higs_n,
  input  logic                 logs_n,
  input  logic                 pd,
  output logic [IDB_W-1:0]     idb
);

  logic             en_pgs;
  logic             en_pcr;
  logic             en_pics;
  logic             en_picv;
  logic             en_mask;
  logic             en_ext;
  logic [IDB_W-1:0] pgs_word;
  logic [IDB_W-1:0] pics_word;
  logic [IDB_W-1:0] picv_word;

  // active-high enables.
  assign en_pgs  = ~bus.epgs_n;
  assign en_pcr  = ~bus.epcr_n;
  assign en_pics = ~bus.epics_n;
  assign en_picv = ~bus.epicv_n;
  assign en_mask = ~bus.epicmask_n;

  // external data only when no internal source is picked.
  assign en_ext = bus.epgs_n & bus.epcr_n & bus.epics_n & bus.epicv_n & bus.epicmask_n;

  // read-back words, unused bits held at zero.
  always_comb begin
    pgs_word                   = '0;
    pgs_word[PGS_FETCH_BIT]    = pgs[PGS_FETCH_BIT];
    pgs_word[PGS_VALID_BIT]    = pgs[PGS_VALID_BIT];
    pgs_word[PGS_PAGE_W-1:0]   = pgs[PGS_PAGE_W-1:0];

    // status word carries the in-service level and the status pins.
    pics_word                  = '0;
    pics_word[PIC_LVL_W-1:0]   = pics;
    pics_word[PICS_HIGS_BIT]   = higs_n;
    pics_word[PICS_LOGS_BIT]   = logs_n;

    // vector word carries the next level and pd.
    picv_word                  = '0;
    picv_word[PIC_LVL_W-1:0]   = picv;
    picv_word[PICV_PD_BIT]     = pd;
  end

  // one AND-OR term per source.
  assign idb = ({IDB_W{en_pgs}}  & pgs_word)
             | ({IDB_W{en_pcr}}  & pcr & PCR_RB_MASK)
             | ({IDB_W{en_pics}} & pics_word)
             | ({IDB_W{en_picv}} & picv_word)
             | ({IDB_W{en_mask}} & picmask)
             | ({IDB_W{en_ext}}  & ext_data);

endmodule

//--- cga_regif.sv
// wishbone classic slave for the IDB read-back path.
// ack comes one cycle after cyc and stb are seen and lasts one cycle.
// register updates land on the edge that ends ack, so read data in the
// ack cycle still shows the state from before the access.
`timescale 1ns/100ps

module cga_regif
  import cga_idb_pkg::*;
(
  input  logic             mclk,
  input  logic             reset,
  input  logic             cyc,
  input  logic             stb,
  input  logic             we,
  input  logic [ADR_W-1:0] adr,
  input  logic [IDB_W-1:0] dat_i,
  output logic             ack,
  output logic [IDB_W-1:0] pcr,
  cga_idb_if.dec           bus
);

  logic req;
  logic start;

  // a transfer is open while cyc and stb are both high.
  assign req = cyc & stb;

  // first cycle of a transfer, ack not yet given.
  assign start = req & ~ack;

  // address decode into active-low read enables.
  // addresses 5 to 7 leave every enable high, so the external data shows.
  always_comb begin
    bus.epgs_n     = ~(req & (adr == ADR_PGS));
    bus.epcr_n     = ~(req & (adr == ADR_PCR));
    bus.epics_n    = ~(req & (adr == ADR_PICS));
    bus.epicv_n    = ~(req & (adr == ADR_PICV));
    bus.epicmask_n = ~(req & (adr == ADR_PICMASK));
  end

  // ack and the strobes rise together on the edge after start.
  // a master that drops stb first never reaches this edge, so no strobe fires.
  always_ff @(posedge mclk) begin
    if (reset) begin
      ack         <= 1'b0;
      bus.rd_pgs  <= 1'b0;
      bus.rd_picv <= 1'b0;
      bus.wr_pcr  <= 1'b0;
      bus.wr_mask <= 1'b0;
    end else begin
      ack         <= start;
      // reads with side effects.
      bus.rd_pgs  <= start & ~we & (adr == ADR_PGS);
      bus.rd_picv <= start & ~we & (adr == ADR_PICV);
      // writable registers, writes elsewhere are dropped.
      bus.wr_pcr  <= start & we & (adr == ADR_PCR);
      bus.wr_mask <= start & we & (adr == ADR_PICMASK);
    end
  end

  // write data is captured with the strobe and held through ack.
  always_ff @(posedge mclk) begin
    if (start) begin
      bus.wdat <= dat_i;
    end
  end

  // paging control register.
  // all 16 bits are stored, the read-back mask sits in the selector.
  always_ff @(posedge mclk) begin
    if (reset) begin
      pcr <= '0;
    end else if (bus.wr_pcr) begin
      pcr <= bus.wdat;
    end
  end

endmodule

//--- cga_idb_if.sv
// decoded read enables, one-cycle strobes and latched write data.
// enables are active low, at most one is low at a time.
`timescale 1ns/100ps

interface cga_idb_if import cga_idb_pkg::*; ();

  // read enables, low while the matching address is on the bus.
  logic             epgs_n;
  logic             epcr_n;
  logic             epics_n;
  logic             epicv_n;
  logic             epicmask_n;

  // single-cycle strobes, high during the ack cycle.
  logic             rd_pgs;
  logic             rd_picv;
  logic             wr_pcr;
  logic             wr_mask;

  // write data, held from the start of the transfer.
  logic [IDB_W-1:0] wdat;

  modport dec (
    output epgs_n, epcr_n, epics_n, epicv_n, epicmask_n,
    output rd_pgs, rd_picv, wr_pcr, wr_mask, wdat
  );

  modport sel (input epgs_n, epcr_n, epics_n, epicv_n, epicmask_n);

  modport pgs (input rd_pgs);

  modport pic (input rd_picv, wr_mask, wdat);

endinterface

//--- cga_idb_pkg.sv
// shared widths, address map and read-back layouts for the IDB read-back path.
// widths are fixed by the register layout and are not meant to be changed.
package cga_idb_pkg;

  // internal data bus and wishbone data width.
  localparam int IDB_W = 16;

  // wishbone word address width.
  localparam int ADR_W = 3;

  // read-back address map. addresses 5 to 7 return the external data.
  localparam logic [ADR_W-1:0] ADR_PGS     = 3'd0;
  localparam logic [ADR_W-1:0] ADR_PCR     = 3'd1;
  localparam logic [ADR_W-1:0] ADR_PICS    = 3'd2;
  localparam logic [ADR_W-1:0] ADR_PICV    = 3'd3;
  localparam logic [ADR_W-1:0] ADR_PICMASK = 3'd4;

  // pcr bits that read back, bits 6 to 3 read as zero.
  localparam logic [IDB_W-1:0] PCR_RB_MASK = 16'hff87;

  // page-status word layout.
  // bits 13 and 12 always read zero.
  localparam int PGS_FETCH_BIT = 15;
  localparam int PGS_VALID_BIT = 14;
  localparam int PGS_PAGE_W    = 12;

  // interrupt level number width and number of levels.
  localparam int PIC_LVL_W  = 3;
  localparam int PIC_LEVELS = 8;

  // interrupt status word, level in bits 2 to 0, status pins above it.
  localparam int PICS_HIGS_BIT = 3;
  localparam int PICS_LOGS_BIT = 4;

  // interrupt vector word, level in bits 2 to 0, pd above it.
  localparam int PICV_PD_BIT = 3;

endpackage
